//--- verilog/ip2_sw_pkg.sv
/*
  Software side definitions
  - op-code enum and command field positions
  - static register and execute word layouts
  - status register bit map and execute limits
*/
package ip2_sw_pkg;

  // Op-code order also fixes the status seen-bit of each op
  typedef enum logic [3:0] {
    OP_NOP,
    OP_W_CFG_STATIC,
    OP_R_CFG_STATIC,
    OP_W_CFG_ARRAY,
    OP_R_CFG_ARRAY,
    OP_R_DATA_ARRAY,
    OP_W_STATUS_CLEAR,
    OP_W_EXECUTE
  } sw_op_e;

  // ------------------------------------------------------------
  // Command word fields
  localparam int SW_DATA_W = 24;                 // Command data width
  localparam int ADDR_LSB  = 16;                 // Array address field
  localparam int ADDR_MSB  = 23;
  localparam int ADDR_W    = ADDR_MSB - ADDR_LSB + 1;

  // Static register, low 13 bits, bits 23..13 spare
  typedef struct packed {
    logic       super_pixel_sel;                 // Bit 12
    logic       bx_delay_sign;                   // Bit 11, 1 moves bxclk earlier
    logic [4:0] bx_delay;                        // Bits 10..6
    logic [5:0] bx_period;                       // Bits 5..0, in fw_axi_clk cycles
  } bx_cfg_t;

  // Execute word, fields are not contiguous
  typedef struct packed {
    logic       mask_reset_not;                  // Bit 23
    logic       loopback;                        // Bit 16
    logic [5:0] test_sample;                     // Bits 11..6
    logic [5:0] test_delay;                      // Bits 5..0
  } test_cfg_t;

  // ------------------------------------------------------------
  // Status register bit map
  localparam int STATUS_RESET_BIT = 0;
  localparam int STATUS_OP_LSB    = 1;           // Seen-bits for op 0..7
  localparam int STATUS_DONE_BIT  = 12;
  localparam int STATUS_ERR_BIT   = 31;          // Bad execute configuration

  localparam logic [5:0] MIN_TEST_DELAY = 6'd3;  // Smallest usable test_delay

endpackage

//--- verilog/ip2_dut_pkg.sv
/*
  ASIC side definitions
  - scan chain and array sizes
  - bunch-crossing counter width
  - test1 states and scan_load encoding
*/
package ip2_dut_pkg;

  // ------------------------------------------------------------
  // Chain and array geometry
  localparam int SCAN_BITS   = 64;
  localparam int CFG_WORD_W  = 16;
  localparam int CFG_WORDS   = SCAN_BITS / CFG_WORD_W;    // 4 words
  localparam int CFG_AW      = $clog2(CFG_WORDS);
  localparam int DATA_WORD_W = 32;
  localparam int DATA_WORDS  = SCAN_BITS / DATA_WORD_W;   // 2 words
  localparam int DATA_AW     = $clog2(DATA_WORDS);
  localparam int SHIFT_CNT_W = 7;                         // Holds 0..SCAN_BITS

  localparam int BX_PERIOD_W = 6;                         // bx_cnt and bx_period

  // Test1 sequence
  typedef enum logic [2:0] {
    T1_IDLE,
    T1_DELAY,
    T1_RESET_NOT,
    T1_SHIFT,
    T1_DONE
  } test1_state_e;

  // scan_load level seen by the ASIC
  typedef enum logic {
    SHIFT_REG = 1'b0,                                     // Chain shifts serially
    LOAD_COMP = 1'b1                                      // Parallel load of comparators
  } scan_mode_e;

endpackage

//--- verilog/scan_ctrl_if.sv
/*
  Design internal interfaces
  - scan_ctrl_if: chain strobes from the test sequencer, chain bit 0 back
  - cfg_mem_if: configuration array write port and both readback words
*/
`timescale 1ns/1ns

interface scan_ctrl_if;
  logic load;          // Copy cfg array into input chain
  logic shift;         // Input chain one place towards bit 0
  logic capture;       // Push capture_bit into capture chain MSB
  logic capture_bit;
  logic chain_bit0;    // Bit currently presented on scan_in

  modport master (output load, shift, capture, capture_bit, input chain_bit0);
  modport slave  (input load, shift, capture, capture_bit, output chain_bit0);
endinterface

interface cfg_mem_if;
  import ip2_sw_pkg::*;
  import ip2_dut_pkg::*;

  logic                    wr_en;
  logic [ADDR_W-1:0]       addr;         // Word address for writes and both reads
  logic [CFG_WORD_W-1:0]   wdata;
  logic [2*CFG_WORD_W-1:0] cfg_rdata;    // Word addr+1 above word addr
  logic [DATA_WORD_W-1:0]  data_rdata;

  modport master (output wr_en, addr, wdata, input cfg_rdata, data_rdata);
  modport slave  (input wr_en, addr, wdata, output cfg_rdata, data_rdata);
endinterface

//--- verilog/sw_cmd_ctrl.sv
/*
  Software command controller
  - four-phase req/ack handshake, one op executed per request
  - static register and its unpacking into bx_cfg
  - sticky status register, execute check and start pulse
  - registered readback mux
*/
`timescale 1ns/1ns

module sw_cmd_ctrl (
  input  logic                             fw_axi_clk,
  input  logic                             op_code_w_reset,
  input  logic                             sw_req,
  input  ip2_sw_pkg::sw_op_e               sw_op,
  input  logic [ip2_sw_pkg::SW_DATA_W-1:0] sw_data,
  input  logic                             test_done,
  output logic                             sw_ack,
  output logic [31:0]                      read_data32,
  output logic [31:0]                      read_status32,
  output ip2_sw_pkg::bx_cfg_t              bx_cfg,
  output ip2_sw_pkg::test_cfg_t            test_cfg,
  output logic                             start,
  cfg_mem_if.master                        mem
);
  import ip2_sw_pkg::*;
  import ip2_dut_pkg::*;

  logic [SW_DATA_W-1:0] static_reg;
  logic [31:0]          status_reg;
  logic [31:0]          rd_mux;
  test_cfg_t            exe_cfg;      // Execute word as received
  logic                 exec;         // One cycle per request
  logic                 exe_op;       // Execute while idle
  logic                 delay_ok;
  logic                 launch;
  logic                 busy;         // From start until test_done

  // ------------------------------------------------------------
  // Decode
  assign exec   = sw_req && !sw_ack;  // First edge of a new request
  assign exe_op = exec && (sw_op == OP_W_EXECUTE) && !busy;
  assign launch = exe_op && delay_ok;

  always_comb begin
    exe_cfg.test_delay     = sw_data[5:0];
    exe_cfg.test_sample    = sw_data[11:6];
    exe_cfg.loopback       = sw_data[16];
    exe_cfg.mask_reset_not = sw_data[23];
  end

  // Delay must leave room for RESET_NOT inside the bx period
  assign delay_ok = (exe_cfg.test_delay >= MIN_TEST_DELAY) &&
                    (exe_cfg.test_delay <= bx_cfg.bx_period);

  assign bx_cfg        = bx_cfg_t'(static_reg[$bits(bx_cfg_t)-1:0]);
  assign read_status32 = status_reg;

  // Array port, combinational from the held command
  assign mem.wr_en = exec && (sw_op == OP_W_CFG_ARRAY);
  assign mem.addr  = sw_data[ADDR_MSB:ADDR_LSB];
  assign mem.wdata = sw_data[CFG_WORD_W-1:0];

  always_comb begin
    case (sw_op)
      OP_R_CFG_STATIC: rd_mux = {{(32-SW_DATA_W){1'b0}}, static_reg};  // Zero padded
      OP_R_CFG_ARRAY:  rd_mux = mem.cfg_rdata;
      OP_R_DATA_ARRAY: rd_mux = mem.data_rdata;
      default:         rd_mux = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Handshake, static register and test launch
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      sw_ack     <= 1'b0;
      start      <= 1'b0;
      busy       <= 1'b0;
      static_reg <= '0;
    end else begin
      start <= launch;                            // One-cycle pulse
      if (exec) begin
        sw_ack <= 1'b1;
      end else if (!sw_req) begin
        sw_ack <= 1'b0;                           // Edge after req falls
      end
      if (launch) begin
        busy <= 1'b1;
      end else if (test_done) begin
        busy <= 1'b0;
      end
      if (exec && sw_op == OP_W_CFG_STATIC) begin
        static_reg <= sw_data;
      end
    end
  end

  always_ff @(posedge fw_axi_clk) begin
    if (exec) begin
      read_data32 <= rd_mux;                      // Valid with sw_ack
    end
    if (launch) begin
      test_cfg <= exe_cfg;                        // Held for the whole test
    end
  end

  // ------------------------------------------------------------
  // Sticky status, clear wins over every set
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      status_reg                   <= '0;
      status_reg[STATUS_RESET_BIT] <= 1'b1;
    end else if (exec && sw_op == OP_W_STATUS_CLEAR) begin
      status_reg <= '0;
    end else begin
      if (exec) begin
        status_reg[STATUS_OP_LSB + int'(sw_op)] <= 1'b1;   // Op seen
      end
      if (test_done) begin
        status_reg[STATUS_DONE_BIT] <= 1'b1;
      end
      if (launch) begin
        status_reg[STATUS_DONE_BIT] <= 1'b0;
        status_reg[STATUS_ERR_BIT]  <= 1'b0;
      end else if (exe_op) begin
        status_reg[STATUS_ERR_BIT] <= 1'b1;       // Bad delay, nothing started
      end
    end
  end

endmodule

//--- verilog/bxclk_gen.sv
/*
  Bunch-crossing clock generator
  - bx_cnt runs 1..bx_period, held at 0 for periods below 2
  - bxclk_ana high in the first half of each period
  - bxclk the same wave shifted by bx_delay, either direction
*/
`timescale 1ns/1ns

module bxclk_gen (
  input  logic                                fw_axi_clk,
  input  logic                                op_code_w_reset,
  input  ip2_sw_pkg::bx_cfg_t                 bx_cfg,
  output logic [ip2_dut_pkg::BX_PERIOD_W-1:0] bx_cnt,
  output logic                                bx_wrap,
  output logic                                bxclk_ana,
  output logic                                bxclk
);
  import ip2_dut_pkg::*;

  logic [BX_PERIOD_W:0] period;    // Extra MSB keeps the phase sums
  logic [BX_PERIOD_W:0] cnt;
  logic [BX_PERIOD_W:0] dly;
  logic [BX_PERIOD_W:0] half;
  logic [BX_PERIOD_W:0] phase;     // Counter position as bxclk sees it
  logic                 running;

  assign period  = {1'b0, bx_cfg.bx_period};
  assign cnt     = {1'b0, bx_cnt};
  assign dly     = (BX_PERIOD_W+1)'(bx_cfg.bx_delay);
  assign half    = period >> 1;
  assign running = (bx_cnt != '0);

  // ------------------------------------------------------------
  // Counter, also wraps at once if the period is shortened
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset || bx_cfg.bx_period < BX_PERIOD_W'(2)) begin
      bx_cnt <= '0;
    end else if (bx_cnt >= bx_cfg.bx_period) begin
      bx_cnt <= BX_PERIOD_W'(1);
    end else begin
      bx_cnt <= bx_cnt + 1'b1;
    end
  end

  assign bx_wrap = running && (bx_cnt == bx_cfg.bx_period);

  // Delay modulo the period, one fold is enough for delay up to a period
  always_comb begin
    if (bx_cfg.bx_delay_sign) begin
      phase = cnt + dly;                          // Earlier
    end else begin
      phase = cnt + period - dly;                 // Later
    end
    if (phase > period) begin
      phase = phase - period;
    end
  end

  assign bxclk_ana = running && (cnt <= half);
  assign bxclk     = running && (phase <= half);

endmodule

//--- verilog/scan_test_seq.sv
/*
  Test1 sequencer
  - delay to test_delay, reset_not low for one bx period
  - loads the input chain, then 64 shifts, one per bx period
  - captures scan_out or looped scan_in at test_sample
*/
`timescale 1ns/1ns

module scan_test_seq (
  input  logic                                fw_axi_clk,
  input  logic                                op_code_w_reset,
  input  logic                                start,
  input  ip2_sw_pkg::test_cfg_t               test_cfg,
  input  logic [ip2_dut_pkg::BX_PERIOD_W-1:0] bx_cnt,
  input  logic                                bx_wrap,
  input  logic                                scan_out,
  output logic                                done,
  output logic                                reset_not,
  output logic                                scan_in,
  output logic                                scan_load,
  scan_ctrl_if.master                         scan
);
  import ip2_dut_pkg::*;

  test1_state_e           state;
  logic [SHIFT_CNT_W-1:0] shift_cnt;
  logic                   at_delay;     // Counter at the programmed phase

  assign at_delay = (bx_cnt == test_cfg.test_delay);

  // ------------------------------------------------------------
  // State register
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      state     <= T1_IDLE;
      shift_cnt <= '0;
    end else begin
      case (state)
        T1_IDLE: if (start) state <= T1_DELAY;
        T1_DELAY: if (at_delay) state <= T1_RESET_NOT;
        T1_RESET_NOT: begin
          // Same phase again means one full period has passed
          if (at_delay) begin
            state     <= T1_SHIFT;
            shift_cnt <= '0;
          end
        end
        T1_SHIFT: begin
          if (bx_wrap) begin
            shift_cnt <= shift_cnt + 1'b1;
            if (shift_cnt == SHIFT_CNT_W'(SCAN_BITS - 1)) begin
              state <= T1_DONE;           // Last bit shifted out
            end
          end
        end
        T1_DONE: state <= T1_IDLE;
        default: state <= T1_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Outputs, idle values outside the test
  always_comb begin
    done          = 1'b0;
    reset_not     = 1'b1;
    scan_load     = SHIFT_REG;
    scan_in       = 1'b0;
    scan.load     = 1'b0;
    scan.shift    = 1'b0;
    scan.capture  = 1'b0;
    case (state)
      T1_DELAY: scan_load = LOAD_COMP;
      T1_RESET_NOT: begin
        reset_not = test_cfg.mask_reset_not;    // Masked keeps the ASIC out of reset
        scan_load = LOAD_COMP;
        scan.load = at_delay;                   // Last cycle of the state
      end
      T1_SHIFT: begin
        scan_in      = scan.chain_bit0;
        scan.shift   = bx_wrap;
        // Sample phase above test_delay also catches bit 0
        scan.capture = (bx_cnt == test_cfg.test_sample);
      end
      T1_DONE: done = 1'b1;
      default: done = 1'b0;
    endcase
    scan.capture_bit = test_cfg.loopback ? scan_in : scan_out;
  end

endmodule

//--- verilog/scan_chain_regs.sv
/*
  Scan chain storage
  - configuration array written from software
  - input chain, loaded from the array and shifted towards bit 0
  - capture chain, filled from the MSB
  - array and data readback ports
*/
`timescale 1ns/1ns

module scan_chain_regs (
  input  logic       fw_axi_clk,
  input  logic       op_code_w_reset,
  cfg_mem_if.slave   mem,
  scan_ctrl_if.slave scan
);
  import ip2_sw_pkg::*;
  import ip2_dut_pkg::*;

  logic [CFG_WORD_W-1:0] cfg_array [CFG_WORDS];
  logic [SCAN_BITS-1:0]  cfg_flat;           // Word 0 in the low bits
  logic [SCAN_BITS-1:0]  in_chain;
  logic [SCAN_BITS-1:0]  cap_chain;
  logic [ADDR_W:0]       addr_hi;            // addr + 1 with carry

  // Configuration array, writes past the end are dropped
  always_ff @(posedge fw_axi_clk) begin
    if (mem.wr_en && mem.addr < ADDR_W'(CFG_WORDS)) begin
      cfg_array[mem.addr[CFG_AW-1:0]] <= mem.wdata;
    end
  end

  always_comb begin
    for (int i = 0; i < CFG_WORDS; i++) begin
      cfg_flat[i*CFG_WORD_W +: CFG_WORD_W] = cfg_array[i];
    end
  end

  // ------------------------------------------------------------
  // Chains
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      in_chain  <= '0;
      cap_chain <= '0;
    end else begin
      if (scan.load) begin
        in_chain <= cfg_flat;                                  // Word 0 bit 0 goes first
      end else if (scan.shift) begin
        in_chain <= {1'b0, in_chain[SCAN_BITS-1:1]};
      end
      if (scan.capture) begin
        cap_chain <= {scan.capture_bit, cap_chain[SCAN_BITS-1:1]};  // First bit ends at bit 0
      end
    end
  end

  assign scan.chain_bit0 = in_chain[0];

  // ------------------------------------------------------------
  // Readback, missing words read as zero
  assign addr_hi = {1'b0, mem.addr} + 1'b1;

  always_comb begin
    mem.cfg_rdata = '0;
    if (mem.addr < ADDR_W'(CFG_WORDS)) begin
      mem.cfg_rdata[CFG_WORD_W-1:0] = cfg_array[mem.addr[CFG_AW-1:0]];
    end
    if (addr_hi < (ADDR_W+1)'(CFG_WORDS)) begin
      mem.cfg_rdata[2*CFG_WORD_W-1:CFG_WORD_W] = cfg_array[addr_hi[CFG_AW-1:0]];
    end
    mem.data_rdata = '0;
    if (mem.addr < ADDR_W'(DATA_WORDS)) begin
      mem.data_rdata = cap_chain[mem.addr[DATA_AW-1:0]*DATA_WORD_W +: DATA_WORD_W];
    end
  end

endmodule

//--- verilog/fw_ip2.sv
/*
  Scan-chain tester firmware top
  - software command port with req/ack handshake
  - bunch-crossing clocks and ASIC scan signals
  - command controller, clock generator, test1 sequencer, chain storage
*/
`timescale 1ns/1ns

module fw_ip2 (
  input  logic                             fw_axi_clk,
  input  logic                             op_code_w_reset,
  input  logic                             sw_req,
  input  ip2_sw_pkg::sw_op_e               sw_op,
  input  logic [ip2_sw_pkg::SW_DATA_W-1:0] sw_data,
  input  logic                             scan_out,
  output logic                             sw_ack,
  output logic [31:0]                      read_data32,
  output logic [31:0]                      read_status32,
  output logic                             super_pixel_sel,
  output logic                             reset_not,
  output logic                             scan_in,
  output logic                             scan_load,
  output logic                             bxclk_ana,
  output logic                             bxclk
);
  import ip2_sw_pkg::*;
  import ip2_dut_pkg::*;

  bx_cfg_t                bx_cfg;      // Clock setup from the static register
  test_cfg_t              test_cfg;
  logic                   start;
  logic                   test_done;
  logic [BX_PERIOD_W-1:0] bx_cnt;
  logic                   bx_wrap;

  scan_ctrl_if scan_if ();
  cfg_mem_if   mem_if ();

  // ------------------------------------------------------------
  sw_cmd_ctrl u_cmd (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .sw_req          (sw_req),
    .sw_op           (sw_op),
    .sw_data         (sw_data),
    .test_done       (test_done),
    .sw_ack          (sw_ack),
    .read_data32     (read_data32),
    .read_status32   (read_status32),
    .bx_cfg          (bx_cfg),
    .test_cfg        (test_cfg),
    .start           (start),
    .mem             (mem_if.master)
  );

  bxclk_gen u_bxclk (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .bx_cfg          (bx_cfg),
    .bx_cnt          (bx_cnt),
    .bx_wrap         (bx_wrap),
    .bxclk_ana       (bxclk_ana),
    .bxclk           (bxclk)
  );

  scan_test_seq u_test1 (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .start           (start),
    .test_cfg        (test_cfg),
    .bx_cnt          (bx_cnt),
    .bx_wrap         (bx_wrap),
    .scan_out        (scan_out),
    .done            (test_done),
    .reset_not       (reset_not),
    .scan_in         (scan_in),
    .scan_load       (scan_load),
    .scan            (scan_if.master)
  );

  scan_chain_regs u_chain (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .mem             (mem_if.slave),
    .scan            (scan_if.slave)
  );

  assign super_pixel_sel = bx_cfg.super_pixel_sel;   // Static bit straight to the ASIC

endmodule

//--- sim/fw_ip2_sva.sv
/*
  Concurrent checks on the firmware top
  - req/ack handshake ordering
  - idle outputs after reset
  - reset_not low only inside a scan_load window
*/
`timescale 1ns/1ns

module fw_ip2_sva (
  input logic fw_axi_clk,
  input logic op_code_w_reset,
  input logic sw_req,
  input logic sw_ack,
  input logic reset_not,
  input logic scan_load
);

  // ------------------------------------------------------------
  // Handshake
  ack_rise_on_req: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    $rose(sw_ack) |-> $past(sw_req))
    else $error("sw_ack rose without a pending sw_req");

  ack_fall_after_req: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    $fell(sw_ack) |-> !$past(sw_req))
    else $error("sw_ack fell while sw_req was still high");

  ack_held_by_req: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    sw_ack && sw_req |=> sw_ack)                   // Software stalls by holding req
    else $error("sw_ack dropped during a held sw_req");

  ack_released: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    sw_ack && !sw_req |=> !sw_ack)
    else $error("sw_ack stayed high after sw_req fell");

  // ------------------------------------------------------------
  // Reset values and scan pin pairing
  idle_after_reset: assert property (@(posedge fw_axi_clk)
    op_code_w_reset |=> !sw_ack && reset_not && !scan_load)
    else $error("outputs not idle after reset");

  reset_not_in_load: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    !scan_load |-> reset_not)                      // ASIC reset only in LOAD_COMP
    else $error("reset_not low while scan_load low");

endmodule

bind fw_ip2 fw_ip2_sva sva0 (
  .fw_axi_clk      (fw_axi_clk),
  .op_code_w_reset (op_code_w_reset),
  .sw_req          (sw_req),
  .sw_ack          (sw_ack),
  .reset_not       (reset_not),
  .scan_load       (scan_load)
);

//--- sim/tb_fw_ip2.sv
/*
  Testbench for the scan-chain tester firmware
  - clock, reset, LCG array data, req/ack command task
  - reference model for static, array, data and status reads
  - bx clock shape, two test1 runs and a rejected execute
*/
`timescale 1ns/1ns

module tb_fw_ip2;
  import ip2_sw_pkg::*;

  localparam int          CLK_HALF       = 10;          // 20 ns period
  localparam int          TIMEOUT_CYCLES = 4000;        // Two 64-shift runs at period 8 + setup
  localparam logic [23:0] STATIC_CFG     = 24'hA5_1088; // Period 8, delay 2 later, spare bits set
  localparam logic [23:0] EXE_LOOP       = 24'h01_0143; // Delay 3, sample 5, loopback
  localparam logic [23:0] EXE_MASKED     = 24'h80_0143; // Delay 3, sample 5, reset_not masked
  localparam logic [23:0] EXE_BAD        = 24'h00_0141; // Delay 1 is below the minimum

  logic        fw_axi_clk;
  logic        op_code_w_reset;
  logic        sw_req;
  sw_op_e      sw_op;
  logic [23:0] sw_data;
  logic        scan_out = 1'b0;
  logic        sw_ack;
  logic [31:0] read_data32;
  logic [31:0] read_status32;
  logic        super_pixel_sel;
  logic        reset_not;
  logic        scan_in;
  logic        scan_load;
  logic        bxclk_ana;
  logic        bxclk;

  logic [23:0] model_static;        // Reference model state
  logic [15:0] model_cfg [4];
  logic [31:0] model_data [2];
  logic [31:0] model_status;
  logic [31:0] lcg_state;
  logic [31:0] rdata;               // Last read_data32 with sw_ack high
  int          cycles = 0;
  int          rst_low_cycles = 0;  // Running totals from the negedge monitor
  int          load_high_cycles = 0;
  int          low_base;
  int          load_base;

  fw_ip2 dut0 (.*);

  initial begin
    fw_axi_clk = 1'b0;
    forever #CLK_HALF fw_axi_clk = ~fw_axi_clk;
  end

  always @(posedge fw_axi_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // ASIC stand-in returns scan_in inverted and counts pin activity
  always @(negedge fw_axi_clk) begin
    scan_out = ~scan_in;
    if (!op_code_w_reset) begin
      if (!reset_not) rst_low_cycles++;
      if (scan_load) load_high_cycles++;
    end
  end

  // ------------------------------------------------------------
  // Checks
  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic require(input bit cond, input string what);
    assert (cond) else begin
      $display("check failed at %0t ns: %s", $time, what);
      abort_run();
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Word addr+1 above word addr and 0 for missing words
  function automatic logic [31:0] cfg_pair(input int addr);
    logic [31:0] word;
    word = '0;
    if (addr < 4) word[15:0] = model_cfg[addr];
    if (addr + 1 < 4) word[31:16] = model_cfg[addr+1];
    return word;
  endfunction

  // ------------------------------------------------------------
  // Model update per acknowledged command
  task automatic update_model(input sw_op_e op, input logic [23:0] data);
    logic [5:0] dly;
    dly = data[5:0];
    if (op == OP_W_STATUS_CLEAR) model_status = '0;           // Clear beats its own seen-bit
    else model_status[STATUS_OP_LSB + int'(op)] = 1'b1;
    case (op)
      OP_W_CFG_STATIC: model_static = data;
      OP_W_CFG_ARRAY: if (data[23:16] < 8'd4) model_cfg[data[17:16]] = data[15:0];
      OP_W_EXECUTE: begin
        if (dly < MIN_TEST_DELAY || dly > model_static[5:0]) begin
          model_status[STATUS_ERR_BIT] = 1'b1;                 // Rejected and nothing starts
        end else begin
          model_status[STATUS_ERR_BIT]  = 1'b0;
          model_status[STATUS_DONE_BIT] = 1'b0;
        end
      end
      default: ;
    endcase
  endtask

  // One four-phase transaction with a status check once ack is gone
  task automatic send_command(input sw_op_e op, input logic [23:0] data);
    @(negedge fw_axi_clk);
    sw_op   = op;
    sw_data = data;
    sw_req  = 1'b1;
    do @(negedge fw_axi_clk); while (!sw_ack);
    rdata  = read_data32;                                      // Valid with ack
    @(negedge fw_axi_clk);                                     // Software stalls one cycle
    sw_req = 1'b0;
    do @(negedge fw_axi_clk); while (sw_ack);
    update_model(op, data);
    compare_word("read_status32", read_status32, model_status);
  endtask

  task automatic cfg_readback(input int addr);
    send_command(OP_R_CFG_ARRAY, {8'(addr), 16'h0000});
    compare_word("read_data32 cfg", rdata, cfg_pair(addr));
  endtask

  task automatic data_readback(input int addr);
    send_command(OP_R_DATA_ARRAY, {8'(addr), 16'h0000});
    compare_word("read_data32 data", rdata, (addr < 2) ? model_data[addr] : 32'h0);
  endtask

  task automatic fill_cfg_array();
    logic [31:0] rnd;
    for (int i = 0; i < 4; i++) begin
      rnd = lcg_next();
      send_command(OP_W_CFG_ARRAY, {8'(i), rnd[31:16]});       // Upper LCG bits
    end
  endtask

  // Period 8 with 4 high and bxclk rising 2 cycles after bxclk_ana
  task automatic measure_bx_clocks(input int n_cycles);
    int   last_rise;
    int   ana_rises;
    int   bx_rises;
    int   high;
    logic prev_ana;
    logic prev_bx;
    last_rise = 0;
    ana_rises = 0;
    bx_rises  = 0;
    high      = 0;
    @(negedge fw_axi_clk);
    prev_ana = bxclk_ana;
    prev_bx  = bxclk;
    for (int c = 0; c < n_cycles; c++) begin
      @(negedge fw_axi_clk);
      if (bxclk_ana && !prev_ana) begin
        if (ana_rises > 0) begin
          compare_word("bxclk_ana period", 32'(c - last_rise), 32'd8);
          compare_word("bxclk_ana high cycles", 32'(high), 32'd4);
        end
        ana_rises++;
        last_rise = c;
        high      = 0;
      end
      if (bxclk_ana) high++;
      if (bxclk && !prev_bx && ana_rises > 0) begin
        compare_word("bxclk delay", 32'(c - last_rise), 32'd2);
        bx_rises++;
      end
      prev_ana = bxclk_ana;
      prev_bx  = bxclk;
    end
    require(ana_rises >= 4 && bx_rises >= 3, "bunch-crossing clocks did not toggle");
  endtask

  // Execute and wait for done before checking captured words
  task automatic run_scan_test(input logic [23:0] exe, input int exp_low);
    int base;
    base = rst_low_cycles;
    send_command(OP_W_EXECUTE, exe);
    do @(negedge fw_axi_clk); while (!read_status32[STATUS_DONE_BIT]);
    model_status[STATUS_DONE_BIT] = 1'b1;
    compare_word("read_status32", read_status32, model_status);
    compare_word("reset_not low cycles", 32'(rst_low_cycles - base), 32'(exp_low));
    model_data[0] = {model_cfg[1], model_cfg[0]};              // Sent order with word 0 first
    model_data[1] = {model_cfg[3], model_cfg[2]};
    if (!exe[16]) begin
      model_data[0] = ~model_data[0];                          // ASIC stand-in inverts
      model_data[1] = ~model_data[1];
    end
    for (int a = 0; a < 3; a++) data_readback(a);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  initial begin
    op_code_w_reset = 1'b1;
    sw_req          = 1'b0;
    sw_op           = OP_NOP;
    sw_data         = '0;
    lcg_state       = 32'h541b;
    model_static    = '0;
    model_status    = 32'h0000_0001;                           // Reset bit only
    repeat (3) @(negedge fw_axi_clk);
    op_code_w_reset = 1'b0;
    @(negedge fw_axi_clk);
    compare_word("read_status32", read_status32, model_status);
    require(!sw_ack && reset_not && !scan_load && !scan_in, "outputs not idle after reset");

    // Static register and status seen-bits
    send_command(OP_W_CFG_STATIC, STATIC_CFG);
    send_command(OP_R_CFG_STATIC, 24'h0);
    compare_word("read_data32 static", rdata, {8'h00, model_static});
    compare_word("super_pixel_sel", 32'(super_pixel_sel), 32'(model_static[12]));
    send_command(OP_W_STATUS_CLEAR, 24'h0);

    // Array pairs including reads past the end
    fill_cfg_array();
    for (int a = 0; a <= 4; a++) cfg_readback(a);
    cfg_readback(255);

    measure_bx_clocks(48);

    run_scan_test(EXE_LOOP, 8);                                // Full bx period in reset
    fill_cfg_array();
    run_scan_test(EXE_MASKED, 0);

    // Rejected execute leaves the scan pins idle
    send_command(OP_W_STATUS_CLEAR, 24'h0);
    low_base  = rst_low_cycles;
    load_base = load_high_cycles;
    send_command(OP_W_EXECUTE, EXE_BAD);
    repeat (24) @(negedge fw_axi_clk);
    compare_word("scan_load high cycles", 32'(load_high_cycles - load_base), 32'd0);
    compare_word("reset_not low cycles", 32'(rst_low_cycles - low_base), 32'd0);
    compare_word("read_status32", read_status32, model_status);

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- fw_ip2.f
verilog/ip2_sw_pkg.sv
verilog/ip2_dut_pkg.sv
verilog/scan_ctrl_if.sv
verilog/sw_cmd_ctrl.sv
verilog/bxclk_gen.sv
verilog/scan_test_seq.sv
verilog/scan_chain_regs.sv
verilog/fw_ip2.sv
sim/fw_ip2_sva.sv
sim/tb_fw_ip2.sv

//--- run_sim.sh
#!/bin/sh
# Build the fw_ip2 testbench with Verilator and run it
# The exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fw_ip2 -Mdir obj_dir -f fw_ip2.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/Vtb_fw_ip2
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit 1
fi

echo "simulation finished"
exit 0
